// File: drive_datapath.f
+incdir+test
source/drive_pkg.sv
source/drive_fetch.sv
source/drive_bank.sv
source/drive_iq_sum.sv
source/drive_datapath.sv
test/drive_tb.sv

// File: source/drive_bank.sv
`timescale 1ns/1ps

module drive_bank (
    input  logic                  clk,
    input  logic                  reset_i,

    input  drive_pkg::pc_t        pc_i,
    input  logic                  pc_valid_i,

    input  drive_pkg::inst_wr_t   inst_wr_i,
    input  drive_pkg::env_wr_t    env_wr_i,

    output drive_pkg::bank_out_t  bank_o,
    output drive_pkg::qubit_sel_t qubit_sel_o,
    output logic                  playing_o
);
    import drive_pkg::*;

    localparam int INST_DEPTH = 1 << PC_WIDTH;
    localparam int ENV_DEPTH  = 1 << ENV_ADDR_WIDTH;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_PLAY
    } state_t;

    state_t     state;

    inst_t      inst_mem [INST_DEPTH];
    iq_pair_t   env_mem [ENV_DEPTH];

    inst_t      inst_q;     // Instruction read at pc_i
    env_addr_t  env_addr;   // Next envelope address to read
    env_addr_t  remain;     // Reads still to issue
    env_addr_t  rd_addr;
    logic       rd_issue;

    // Read pipeline
    logic       rd_vld;
    iq_pair_t   rd_data;
    logic       out_valid;
    iq_pair_t   out_iq;

    ////////////////////////////////////////////////////////////
    // Instruction list
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (inst_wr_i.en) begin
            inst_mem[inst_wr_i.addr] <= inst_wr_i.data;
        end
        // A busy bank drops the instruction
        if (pc_valid_i && state == ST_IDLE) begin
            inst_q <= inst_mem[pc_i];
        end
    end

    ////////////////////////////////////////////////////////////
    // Envelope memory
    ////////////////////////////////////////////////////////////

    // First read goes out straight from the fetched instruction
    assign rd_addr  = (state == ST_FETCH) ? inst_q.env_start : env_addr;

    assign rd_issue = ((state == ST_FETCH) && (inst_q.env_len != '0))
                   || ((state == ST_PLAY) && (remain != '0));

    always_ff @(posedge clk) begin
        if (env_wr_i.en) begin
            env_mem[env_wr_i.addr] <= env_wr_i.data;
        end
        rd_data <= env_mem[rd_addr];
    end

    ////////////////////////////////////////////////////////////
    // Playback sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= ST_IDLE;
            remain      <= '0;
            qubit_sel_o <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pc_valid_i) begin
                        state <= ST_FETCH;
                    end
                end

                ST_FETCH: begin
                    if (inst_q.env_len != '0) begin
                        qubit_sel_o <= inst_q.qubit;
                        env_addr    <= inst_q.env_start + 1'b1;  // Start already read
                        remain      <= inst_q.env_len - 1'b1;
                        state       <= ST_PLAY;
                    end else begin
                        state <= ST_IDLE;  // No-op
                    end
                end

                ST_PLAY: begin
                    if (remain != '0) begin
                        env_addr <= env_addr + 1'b1;
                        remain   <= remain - 1'b1;
                    end else if (!rd_vld) begin
                        // Last sample sits in the output register
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_vld    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            rd_vld    <= rd_issue;
            out_valid <= rd_vld;
        end
    end

    always_ff @(posedge clk) begin
        out_iq <= rd_data;
    end

    assign bank_o    = '{valid: out_valid, iq: out_iq};
    assign playing_o = (state != ST_IDLE);

endmodule

// File: source/drive_datapath.sv
`timescale 1ns/1ps

module drive_datapath #(
    parameter int NUM_BANK = 2  // 1 to 4
) (
    input  logic                  clk,
    input  logic                  reset_i,

    input  logic                  update_pc_i,

    // Memory loading
    input  logic [NUM_BANK-1:0]   bank_wr_sel_i,
    input  drive_pkg::inst_wr_t   inst_wr_i,
    input  drive_pkg::env_wr_t    env_wr_i,

    // Per bank status
    output drive_pkg::qubit_sel_t qubit_sel_o [NUM_BANK],
    output logic [NUM_BANK-1:0]   playing_o,

    // Summed stream
    output logic                  valid_o,
    output drive_pkg::iq_sum_t    i_o,
    output drive_pkg::iq_sum_t    q_o
);
    import drive_pkg::*;

    pc_t       pc;
    logic      pc_valid;

    inst_wr_t  inst_wr_bank [NUM_BANK];
    env_wr_t   env_wr_bank [NUM_BANK];
    bank_out_t bank_out [NUM_BANK];

    ////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////

    drive_fetch #(
        .NUM_BANK(NUM_BANK)
    ) i_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .update_pc_i   (update_pc_i),
        .bank_wr_sel_i (bank_wr_sel_i),
        .inst_wr_i     (inst_wr_i),
        .env_wr_i      (env_wr_i),
        .pc_o          (pc),
        .pc_valid_o    (pc_valid),
        .inst_wr_o     (inst_wr_bank),
        .env_wr_o      (env_wr_bank)
    );

    ////////////////////////////////////////////////////////////
    // Banks
    ////////////////////////////////////////////////////////////

    for (genvar b = 0; b < NUM_BANK; b++) begin : gen_bank
        drive_bank i_bank (
            .clk         (clk),
            .reset_i     (reset_i),
            .pc_i        (pc),        // Broadcast
            .pc_valid_i  (pc_valid),
            .inst_wr_i   (inst_wr_bank[b]),
            .env_wr_i    (env_wr_bank[b]),
            .bank_o      (bank_out[b]),
            .qubit_sel_o (qubit_sel_o[b]),
            .playing_o   (playing_o[b])
        );
    end

    ////////////////////////////////////////////////////////////
    // Sum
    ////////////////////////////////////////////////////////////

    drive_iq_sum #(
        .NUM_BANK(NUM_BANK)
    ) i_sum (
        .clk     (clk),
        .reset_i (reset_i),
        .bank_i  (bank_out),
        .valid_o (valid_o),
        .i_o     (i_o),
        .q_o     (q_o)
    );

endmodule

// File: source/drive_fetch.sv
`timescale 1ns/1ps

module drive_fetch #(
    parameter int NUM_BANK = 2
) (
    input  logic                clk,
    input  logic                reset_i,

    input  logic                update_pc_i,

    input  logic [NUM_BANK-1:0] bank_wr_sel_i,
    input  drive_pkg::inst_wr_t inst_wr_i,
    input  drive_pkg::env_wr_t  env_wr_i,

    output drive_pkg::pc_t      pc_o,
    output logic                pc_valid_o,

    output drive_pkg::inst_wr_t inst_wr_o [NUM_BANK],
    output drive_pkg::env_wr_t  env_wr_o [NUM_BANK]
);
    import drive_pkg::*;

    pc_t pc_cnt;  // Next instruction to issue

    ////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_cnt     <= '0;
            pc_valid_o <= 1'b0;
        end else begin
            pc_valid_o <= update_pc_i;  // One cycle pulse
            if (update_pc_i) begin
                pc_cnt <= pc_cnt + 1'b1;  // Wraps at the list end
            end
        end
    end

    // Address held until the next strobe
    always_ff @(posedge clk) begin
        if (update_pc_i) begin
            pc_o <= pc_cnt;
        end
    end

    ////////////////////////////////////////////////////////////
    // Write fan-out
    ////////////////////////////////////////////////////////////

    // Same address and data everywhere, enable only where selected
    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            inst_wr_o[b]    = inst_wr_i;
            inst_wr_o[b].en = inst_wr_i.en & bank_wr_sel_i[b];

            env_wr_o[b]     = env_wr_i;
            env_wr_o[b].en  = env_wr_i.en & bank_wr_sel_i[b];
        end
    end

endmodule

// File: source/drive_iq_sum.sv
`timescale 1ns/1ps

module drive_iq_sum #(
    parameter int NUM_BANK = 2  // 1 to MAX_BANK
) (
    input  logic                 clk,
    input  logic                 reset_i,

    input  drive_pkg::bank_out_t bank_i [NUM_BANK],

    output logic                 valid_o,
    output drive_pkg::iq_sum_t   i_o,
    output drive_pkg::iq_sum_t   q_o
);
    import drive_pkg::*;

    iq_sum_t i_acc;
    iq_sum_t q_acc;
    logic    valid_any;

    // Idle banks contribute nothing
    always_comb begin
        i_acc     = '0;
        q_acc     = '0;
        valid_any = 1'b0;
        for (int b = 0; b < NUM_BANK; b++) begin
            if (bank_i[b].valid) begin
                i_acc     = i_acc + iq_sum_t'(bank_i[b].iq.i);  // Sign extended
                q_acc     = q_acc + iq_sum_t'(bank_i[b].iq.q);
                valid_any = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_any;
        end
    end

    always_ff @(posedge clk) begin
        i_o <= i_acc;
        q_o <= q_acc;
    end

endmodule

// File: source/drive_pkg.sv
package drive_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int PC_WIDTH         = 8;  // Also instruction list depth exponent
    localparam int ENV_ADDR_WIDTH   = 8;
    localparam int QUBIT_ADDR_WIDTH = 4;
    localparam int IQ_WIDTH         = 9;
    localparam int MAX_BANK         = 4;

    // Headroom for summing up to MAX_BANK banks
    localparam int IQ_SUM_WIDTH = IQ_WIDTH + $clog2(MAX_BANK);

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    typedef logic [PC_WIDTH-1:0]                pc_t;
    typedef logic [ENV_ADDR_WIDTH-1:0]          env_addr_t;  // Address or length
    typedef logic [QUBIT_ADDR_WIDTH-1:0]        qubit_sel_t;
    typedef logic signed [IQ_WIDTH-1:0]         iq_sample_t;
    typedef logic signed [IQ_SUM_WIDTH-1:0]     iq_sum_t;

    ////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////

    // One drive instruction, zero length is a no-op
    typedef struct packed {
        qubit_sel_t qubit;
        env_addr_t  env_start;
        env_addr_t  env_len;
    } inst_t;

    typedef struct packed {
        iq_sample_t i;
        iq_sample_t q;
    } iq_pair_t;

    // Sample leaving a bank
    typedef struct packed {
        logic     valid;
        iq_pair_t iq;
    } bank_out_t;

    // Instruction list write port
    typedef struct packed {
        logic  en;
        pc_t   addr;
        inst_t data;
    } inst_wr_t;

    // Envelope memory write port
    typedef struct packed {
        logic      en;
        env_addr_t addr;
        iq_pair_t  data;
    } env_wr_t;

endpackage

// File: test/drive_tb_checks.svh
`ifndef DRIVE_TB_CHECKS_SVH
`define DRIVE_TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// Counters and clock stepping
////////////////////////////////////////////////////////////

localparam int TIMEOUT = 200;  // Cycles per wait

int check_count = 0;
int error_count = 0;
int test_count  = 0;

// Lands 1 ns after the rising edge
task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

////////////////////////////////////////////////////////////
// Typed compares
////////////////////////////////////////////////////////////

task automatic check_iq(input string name, input iq_sum_t got, input iq_sum_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_qubit(input string name, input qubit_sel_t got, input qubit_sel_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

////////////////////////////////////////////////////////////
// Waits
////////////////////////////////////////////////////////////

task automatic wait_for_valid(output bit ok);
    int cycles;
    cycles = 0;
    while (valid !== 1'b1 && cycles < TIMEOUT) begin
        next_cycle();
        cycles++;
    end
    ok = (valid === 1'b1);
    if (!ok) begin
        error_count++;
        $display("timeout at %0t: valid_o never rose after the strobe", $time);
    end
endtask

// All banks back to idle
task automatic wait_for_idle(output bit ok);
    int cycles;
    cycles = 0;
    while (playing !== '0 && cycles < TIMEOUT) begin
        next_cycle();
        cycles++;
    end
    ok = (playing === '0);
    if (!ok) begin
        error_count++;
        $display("timeout at %0t: banks still playing", $time);
    end
endtask

task automatic report_test(input string name, input int errors_before);
    test_count++;
    $display("%s: %0d errors", name, error_count - errors_before);
endtask

`endif

// File: test/drive_tb.sv
`timescale 1ns/1ps

module drive_tb;
    import drive_pkg::*;

    localparam int NUM_BANK = 2;

    logic                clk = 1'b0;
    logic                reset;
    logic                update_pc;
    logic [NUM_BANK-1:0] bank_wr_sel;
    inst_wr_t            inst_wr;
    env_wr_t             env_wr;
    qubit_sel_t          qubit_sel [NUM_BANK];
    logic [NUM_BANK-1:0] playing;
    logic                valid;
    iq_sum_t             i_sum;
    iq_sum_t             q_sum;

    // Mirror of what each bank holds
    inst_t    ref_inst [NUM_BANK][1 << PC_WIDTH];
    iq_pair_t ref_env [NUM_BANK][1 << ENV_ADDR_WIDTH];
    pc_t      exp_pc;  // Program counter model

    `include "drive_tb_checks.svh"

    drive_datapath #(
        .NUM_BANK(NUM_BANK)
    ) i_dut (
        .clk           (clk),
        .reset_i       (reset),
        .update_pc_i   (update_pc),
        .bank_wr_sel_i (bank_wr_sel),
        .inst_wr_i     (inst_wr),
        .env_wr_i      (env_wr),
        .qubit_sel_o   (qubit_sel),
        .playing_o     (playing),
        .valid_o       (valid),
        .i_o           (i_sum),
        .q_o           (q_sum)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Memory loading
    ////////////////////////////////////////////////////////////

    task automatic write_inst(input logic [NUM_BANK-1:0] sel, input pc_t addr, input inst_t data);
        bank_wr_sel = sel;
        inst_wr     = '{en: 1'b1, addr: addr, data: data};
        next_cycle();
        inst_wr.en  = 1'b0;
        for (int b = 0; b < NUM_BANK; b++) begin
            if (sel[b]) begin
                ref_inst[b][addr] = data;
            end
        end
    endtask

    // Random samples from start upward
    task automatic load_envelope(input logic [NUM_BANK-1:0] sel, input env_addr_t start,
                                 input int len);
        iq_pair_t  pair;
        env_addr_t addr;
        for (int k = 0; k < len; k++) begin
            addr        = env_addr_t'(start + k);  // Wraps
            pair.i      = iq_sample_t'($urandom);
            pair.q      = iq_sample_t'($urandom);
            bank_wr_sel = sel;
            env_wr      = '{en: 1'b1, addr: addr, data: pair};
            next_cycle();
            for (int b = 0; b < NUM_BANK; b++) begin
                if (sel[b]) begin
                    ref_env[b][addr] = pair;
                end
            end
        end
        env_wr.en = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic iq_sum_t expected_sum(input pc_t idx, input int k, input bit use_q);
        int         acc;
        inst_t      inst;
        iq_sample_t sample;
        acc = 0;
        for (int b = 0; b < NUM_BANK; b++) begin
            inst = ref_inst[b][idx];
            if (k < int'(inst.env_len)) begin  // Bank still playing
                sample = use_q ? ref_env[b][env_addr_t'(inst.env_start + k)].q
                               : ref_env[b][env_addr_t'(inst.env_start + k)].i;
                acc += int'(sample);
            end
        end
        return iq_sum_t'(acc);
    endfunction

    function automatic int play_length(input pc_t idx);
        int len;
        len = 0;
        for (int b = 0; b < NUM_BANK; b++) begin
            if (int'(ref_inst[b][idx].env_len) > len) begin
                len = int'(ref_inst[b][idx].env_len);
            end
        end
        return len;
    endfunction

    // Plays the next instruction, optionally strobing again at sample strobe_at
    task automatic play_instruction(input int strobe_at);
        pc_t idx;
        int  len;
        bit  ok;
        wait_for_idle(ok);
        idx       = exp_pc;
        len       = play_length(idx);
        update_pc = 1'b1;
        next_cycle();
        update_pc = 1'b0;
        exp_pc++;
        wait_for_valid(ok);
        if (!ok) begin
            return;
        end
        for (int k = 0; k < len; k++) begin
            check_bit("valid_o", valid, 1'b1);
            check_iq("i_o", i_sum, expected_sum(idx, k, 1'b0));
            check_iq("q_o", q_sum, expected_sum(idx, k, 1'b1));
            for (int b = 0; b < NUM_BANK; b++) begin
                check_bit($sformatf("playing_o[%0d]", b), playing[b],
                          k + 1 < ref_inst[b][idx].env_len);
                if (ref_inst[b][idx].env_len != 0) begin
                    check_qubit($sformatf("qubit_sel_o[%0d]", b), qubit_sel[b],
                                ref_inst[b][idx].qubit);
                end
            end
            update_pc = (k == strobe_at);
            next_cycle();
            if (update_pc) begin
                exp_pc++;  // Consumed by busy banks
            end
            update_pc = 1'b0;
        end
        check_bit("valid_o", valid, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic reset_state();
        int errors_before;
        errors_before = error_count;
        check_bit("valid_o", valid, 1'b0);
        for (int b = 0; b < NUM_BANK; b++) begin
            check_bit($sformatf("playing_o[%0d]", b), playing[b], 1'b0);
            check_qubit($sformatf("qubit_sel_o[%0d]", b), qubit_sel[b], '0);
        end
        report_test("reset_state", errors_before);
    endtask

    // Instruction 0 first, so the counter starts at 0
    task automatic single_bank_play();
        int errors_before;
        errors_before = error_count;
        load_envelope(2'b01, 8'h10, 5);
        write_inst(2'b01, 8'd0, inst_t'{4'd3, 8'h10, 8'd5});
        write_inst(2'b10, 8'd0, inst_t'{4'd7, 8'h00, 8'd0});
        play_instruction(-1);
        report_test("single_bank_play", errors_before);
    endtask

    task automatic two_bank_sum();
        int errors_before;
        errors_before = error_count;
        load_envelope(2'b01, 8'h20, 3);
        load_envelope(2'b10, 8'h40, 7);
        write_inst(2'b01, 8'd1, inst_t'{4'd5, 8'h20, 8'd3});
        write_inst(2'b10, 8'd1, inst_t'{4'd9, 8'h40, 8'd7});
        play_instruction(-1);
        report_test("two_bank_sum", errors_before);
    endtask

    task automatic successive_strobes();
        int errors_before;
        errors_before = error_count;
        load_envelope(2'b01, 8'hfc, 6);  // Crosses the top of memory
        load_envelope(2'b10, 8'h50, 5);
        write_inst(2'b01, 8'd2, inst_t'{4'd1, 8'hfc, 8'd6});
        write_inst(2'b10, 8'd2, inst_t'{4'd2, 8'h40, 8'd4});
        write_inst(2'b01, 8'd3, inst_t'{4'd4, 8'h10, 8'd2});
        write_inst(2'b10, 8'd3, inst_t'{4'd6, 8'h50, 8'd5});
        play_instruction(-1);
        play_instruction(-1);
        report_test("successive_strobes", errors_before);
    endtask

    task automatic write_select();
        int errors_before;
        errors_before = error_count;
        load_envelope(2'b11, 8'h60, 4);  // Same content, doubled output
        write_inst(2'b11, 8'd4, inst_t'{4'd8, 8'h60, 8'd4});
        play_instruction(-1);
        load_envelope(2'b10, 8'h62, 1);  // Bank 1 only
        write_inst(2'b11, 8'd5, inst_t'{4'd9, 8'h60, 8'd4});
        play_instruction(-1);
        report_test("write_select", errors_before);
    endtask

    task automatic strobe_while_busy();
        int errors_before;
        errors_before = error_count;
        load_envelope(2'b01, 8'h80, 10);
        load_envelope(2'b10, 8'h90, 10);
        write_inst(2'b01, 8'd6, inst_t'{4'd10, 8'h80, 8'd10});
        write_inst(2'b10, 8'd6, inst_t'{4'd11, 8'h90, 8'd10});
        write_inst(2'b11, 8'd7, inst_t'{4'd12, 8'h20, 8'd2});
        write_inst(2'b01, 8'd8, inst_t'{4'd13, 8'h10, 8'd3});
        write_inst(2'b10, 8'd8, inst_t'{4'd14, 8'h40, 8'd2});
        play_instruction(2);
        play_instruction(-1);  // Instruction 8
        report_test("strobe_while_busy", errors_before);
    endtask

    initial begin
        void'($urandom(32'h2cf));
        reset       = 1'b1;
        update_pc   = 1'b0;
        bank_wr_sel = '0;
        inst_wr     = '0;
        env_wr      = '0;
        exp_pc      = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_state();
        single_bank_play();
        two_bank_sum();
        successive_strobes();
        write_select();
        strobe_while_busy();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
